// File: hdl/gbSysPkg.sv
package gbSysPkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int addrWidth = 16;
  localparam int dataWidth = 8;
  localparam int numIrq    = 4;   // VBlank, LCD status, timer, joypad

  typedef logic [addrWidth-1:0] addrT;
  typedef logic [dataWidth-1:0] dataT;
  typedef logic [numIrq-1:0]    irqT;

  localparam addrT resetPc = 16'h0000;

  // --------------------------------------------------------------------------
  // Interrupt entry points
  // --------------------------------------------------------------------------
  localparam addrT vecVblank  = 16'h0040;
  localparam addrT vecLcdStat = 16'h0048;
  localparam addrT vecTimer   = 16'h0050;
  localparam addrT vecJoypad  = 16'h0060;

  // Sequencer steps
  typedef enum logic [2:0] {
    stateFetch,
    stateExecute,
    stateOperand,   // immediate byte of LD r,n
    stateStore,     // write for LD (HL),r
    stateVector
  } seqStateT;

endpackage

// File: hdl/gbIsaPkg.sv
package gbIsaPkg;

  // Register codes as they sit in the opcode fields
  typedef logic [2:0] regCodeT;

  localparam regCodeT regB   = 3'd0;
  localparam regCodeT regC   = 3'd1;
  localparam regCodeT regD   = 3'd2;
  localparam regCodeT regE   = 3'd3;
  localparam regCodeT regH   = 3'd4;
  localparam regCodeT regL   = 3'd5;
  localparam regCodeT regMem = 3'd6;   // (HL)
  localparam regCodeT regA   = 3'd7;

  // --------------------------------------------------------------------------
  // Opcode byte, whole or split into x/y/z
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [1:0] x;
    logic [2:0] y;
    logic [2:0] z;
  } opFieldsT;

  typedef union packed {
    logic [7:0] raw;
    opFieldsT   fields;
  } opcodeU;

  typedef enum logic [2:0] {aluMove, aluAnd, aluXor, aluOr, aluInc, aluDec} aluOpT;

  localparam logic [7:0] opNop  = 8'h00;
  localparam logic [7:0] opDi   = 8'hF3;
  localparam logic [7:0] opEi   = 8'hFB;
  localparam logic [7:0] opHalt = 8'h76;   // runs as NOP

  localparam logic [1:0] classLdRR = 2'd1;
  localparam logic [1:0] classAlu  = 2'd2;

  localparam logic [2:0] aluYAnd = 3'd4;
  localparam logic [2:0] aluYXor = 3'd5;
  localparam logic [2:0] aluYOr  = 3'd6;

  localparam logic [2:0] zInc   = 3'd4;
  localparam logic [2:0] zDec   = 3'd5;
  localparam logic [2:0] zLdImm = 3'd6;

endpackage

// File: hdl/regPortIf.sv
`timescale 1ns/1ns

interface regPortIf;

  gbIsaPkg::regCodeT readSelA;
  gbIsaPkg::regCodeT readSelB;
  gbSysPkg::dataT    readDataA;   // Combinational
  gbSysPkg::dataT    readDataB;
  logic              writeEnable;
  gbIsaPkg::regCodeT writeSelect;
  gbSysPkg::dataT    writeData;

  modport controller (
    output readSelA, readSelB, writeEnable, writeSelect, writeData,
    input  readDataA, readDataB
  );

  modport bank (
    input  readSelA, readSelB, writeEnable, writeSelect, writeData,
    output readDataA, readDataB
  );

endinterface

// File: hdl/interruptController.sv
`timescale 1ns/1ns

module interruptController (
  input  logic           iClock,
  input  logic           rstN,
  input  gbSysPkg::irqT  interruptRequests,
  input  logic           enableSet,
  input  logic           enableClear,
  input  logic           take,
  output logic           pending,
  output gbSysPkg::addrT vector
);
  import gbSysPkg::*;

  irqT  latch;
  irqT  latchNext;
  logic enable;
  logic enableNext;

  // Requests stick until an entry serves them
  assign latchNext  = take ? '0 : (latch | interruptRequests);
  assign enableNext = (take || enableClear) ? 1'b0 : (enableSet ? 1'b1 : enable);

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      latch  <= '0;
      enable <= 1'b0;
    end
    else
    begin
      latch  <= latchNext;
      enable <= enableNext;
    end
  end

  // State of the coming cycle, so the sequencer can hold back a fetch strobe
  assign pending = enableNext && (latchNext != '0);

  always_comb
  begin
    if (latch[3])
      vector = vecJoypad;      // Joypad wins over all
    else if (latch[0])
      vector = vecVblank;
    else if (latch[1])
      vector = vecLcdStat;
    else
      vector = vecTimer;
  end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ns

module registerFile (
  input  logic   iClock,
  input  logic   rstN,
  regPortIf.bank regs
);
  import gbSysPkg::*;
  import gbIsaPkg::*;

  dataT regArray [0:6];   // B C D E H L A

  // A takes slot 6, left free by the (HL) code
  function automatic regCodeT slotOf(input regCodeT code);
    return (code == regA) ? regMem : code;
  endfunction

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < $size(regArray); i++)
        regArray[i] <= '0;
    end
    else if (regs.writeEnable && regs.writeSelect != regMem)
    begin
      regArray[slotOf(regs.writeSelect)] <= regs.writeData;
    end
  end

  // ---------------------------------------------------------------------------
  // Read ports
  // ---------------------------------------------------------------------------
  assign regs.readDataA = (regs.readSelA == regMem) ? '0 : regArray[slotOf(regs.readSelA)];
  assign regs.readDataB = (regs.readSelB == regMem) ? '0 : regArray[slotOf(regs.readSelB)];

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
  input  gbIsaPkg::aluOpT op,
  input  gbSysPkg::dataT  a,
  input  gbSysPkg::dataT  b,
  output gbSysPkg::dataT  result
);
  import gbIsaPkg::*;

  // a is the accumulator side, b the selected register or bus byte
  always_comb
  begin
    case (op)
      aluMove: result = b;
      aluAnd:  result = a & b;
      aluXor:  result = a ^ b;
      aluOr:   result = a | b;
      aluInc:  result = b + 8'd1;   // Wraps at FF
      aluDec:  result = b - 8'd1;
      default: result = b;
    endcase
  end

endmodule

// File: hdl/cpuSequencer.sv
`timescale 1ns/1ns

module cpuSequencer (
  input  logic            iClock,
  input  logic            rstN,
  input  gbSysPkg::dataT  mcuDataIn,
  output gbSysPkg::addrT  mcuAddr,
  output gbSysPkg::dataT  mcuDataOut,
  output logic            mcuReadRequest,
  output logic            mcuWe,
  regPortIf.controller    regs,
  output gbIsaPkg::aluOpT aluOp,
  output gbSysPkg::dataT  aluA,
  output gbSysPkg::dataT  aluB,
  input  gbSysPkg::dataT  aluResult,
  input  logic            irqPending,
  input  gbSysPkg::addrT  irqVector,
  output logic            irqTake,
  output logic            intEnableSet,
  output logic            intEnableClear
);
  import gbSysPkg::*;
  import gbIsaPkg::*;

  seqStateT state;
  addrT     pc;
  addrT     pcNext;
  opcodeU   opcodeReg;
  opcodeU   curOp;
  logic     fetchStrobe;   // Read strobe of the Fetch cycle
  regCodeT  srcSel;
  regCodeT  dstSel;
  logic     writesNow;
  logic     isLdImm;
  logic     isStore;
  logic     isEi;
  logic     isDi;

  assign pcNext = pc + 16'd1;

  // Opcode is on the bus during Execute, held afterwards
  always_comb
    curOp.raw = (state == stateExecute) ? mcuDataIn : opcodeReg.raw;

  // ---------------------------------------------------------------------------
  // Decode
  // ---------------------------------------------------------------------------
  always_comb
  begin
    aluOp     = aluMove;
    srcSel    = curOp.fields.z;
    dstSel    = curOp.fields.y;
    writesNow = 1'b0;
    isLdImm   = 1'b0;
    isStore   = 1'b0;
    isEi      = 1'b0;
    isDi      = 1'b0;
    if (curOp.raw == opEi)
      isEi = 1'b1;
    else if (curOp.raw == opDi)
      isDi = 1'b1;
    else if (curOp.raw != opNop && curOp.raw != opHalt)
    begin
      case (curOp.fields.x)
        2'b00:   // LD r,n / INC r / DEC r
        begin
          srcSel  = curOp.fields.y;
          isLdImm = (curOp.fields.z == zLdImm);
          if (curOp.fields.z == zInc)
          begin
            aluOp     = aluInc;
            writesNow = 1'b1;
          end
          else if (curOp.fields.z == zDec)
          begin
            aluOp     = aluDec;
            writesNow = 1'b1;
          end
        end
        classLdRR:
        begin
          isStore   = (curOp.fields.y == regMem);
          writesNow = !isStore;
        end
        classAlu:
        begin
          dstSel = regA;
          case (curOp.fields.y)
            aluYAnd: aluOp = aluAnd;
            aluYXor: aluOp = aluXor;
            aluYOr:  aluOp = aluOr;
            default: aluOp = aluMove;
          endcase
          writesNow = (aluOp != aluMove);   // ADD/SUB/CP group dropped
        end
        default: writesNow = 1'b0;   // CB prefix and the rest
      endcase
    end
  end

  // Register file and ALU steering
  assign regs.readSelA    = (state == stateStore) ? regH : regA;
  assign regs.readSelB    = (state == stateStore) ? regL : srcSel;
  assign regs.writeEnable = (state == stateExecute && writesNow) || state == stateOperand;
  assign regs.writeSelect = dstSel;
  assign regs.writeData   = aluResult;
  assign aluA = regs.readDataA;
  assign aluB = (state == stateOperand) ? mcuDataIn : regs.readDataB;

  assign intEnableSet   = (state == stateExecute) && isEi;
  assign intEnableClear = (state == stateExecute) && isDi;
  assign irqTake        = (state == stateVector);

  // ---------------------------------------------------------------------------
  // Memory port
  // ---------------------------------------------------------------------------
  assign mcuReadRequest = fetchStrobe || (state == stateExecute && isLdImm);
  assign mcuWe          = (state == stateStore);

  always_comb
  begin
    case (state)
      stateExecute: mcuAddr = pcNext;   // immediate byte
      stateStore:   mcuAddr = {regs.readDataA, regs.readDataB};
      default:      mcuAddr = pc;
    endcase
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      state       <= stateFetch;
      pc          <= resetPc;
      fetchStrobe <= 1'b0;
    end
    else
    begin
      case (state)
        stateFetch:
        begin
          if (fetchStrobe)
          begin
            fetchStrobe <= 1'b0;
            state       <= stateExecute;
          end
          else if (irqPending)
            state <= stateVector;
          else
            fetchStrobe <= 1'b1;   // only right after reset
        end
        stateExecute:
        begin
          pc <= pcNext;
          if (isLdImm)
            state <= stateOperand;
          else if (isStore)
            state <= stateStore;
          else
          begin
            state       <= stateFetch;
            fetchStrobe <= !irqPending;
          end
        end
        stateOperand:
        begin
          pc          <= pcNext;
          state       <= stateFetch;
          fetchStrobe <= !irqPending;
        end
        stateVector:
        begin
          pc          <= irqVector;
          state       <= stateFetch;
          fetchStrobe <= !irqPending;
        end
        default:   // Store
        begin
          state       <= stateFetch;
          fetchStrobe <= !irqPending;
        end
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (state == stateExecute)
    begin
      opcodeReg.raw <= mcuDataIn;
      mcuDataOut    <= regs.readDataB;   // source register of a store
    end
  end

endmodule

// File: hdl/gbCore.sv
`timescale 1ns/1ns

module gbCore (
  input  logic           iClock,
  input  logic           rstN,
  input  gbSysPkg::dataT mcuDataIn,
  input  gbSysPkg::irqT  interruptRequests,
  output gbSysPkg::addrT mcuAddr,
  output gbSysPkg::dataT mcuDataOut,
  output logic           mcuReadRequest,
  output logic           mcuWe
);

  gbIsaPkg::aluOpT aluOp;
  gbSysPkg::dataT  aluA;
  gbSysPkg::dataT  aluB;
  gbSysPkg::dataT  aluResult;
  logic            irqPending;
  gbSysPkg::addrT  irqVector;
  logic            irqTake;
  logic            intEnableSet;
  logic            intEnableClear;

  regPortIf regBus ();

  cpuSequencer uSequencer (
    .iClock(iClock),                 .rstN(rstN),
    .mcuDataIn(mcuDataIn),           .mcuAddr(mcuAddr),
    .mcuDataOut(mcuDataOut),         .mcuReadRequest(mcuReadRequest),
    .mcuWe(mcuWe),                   .regs(regBus.controller),
    .aluOp(aluOp),                   .aluA(aluA),
    .aluB(aluB),                     .aluResult(aluResult),
    .irqPending(irqPending),         .irqVector(irqVector),
    .irqTake(irqTake),               .intEnableSet(intEnableSet),
    .intEnableClear(intEnableClear)
  );

  registerFile uRegFile (.iClock(iClock), .rstN(rstN), .regs(regBus.bank));

  aluUnit uAlu (.op(aluOp), .a(aluA), .b(aluB), .result(aluResult));

  interruptController uIrq (
    .iClock(iClock),       .rstN(rstN),
    .interruptRequests(interruptRequests),
    .enableSet(intEnableSet), .enableClear(intEnableClear),
    .take(irqTake),        .pending(irqPending),
    .vector(irqVector)
  );

endmodule

// File: bench/gbCore_props.sv
`timescale 1ns/1ns

module gbCoreProps (
  input logic           iClock,
  input logic           rstN,
  input gbSysPkg::addrT mcuAddr,
  input logic           mcuReadRequest,
  input logic           mcuWe
);

  int failCount = 0;   // Failed assertions so far

  // ---------------------------------------------------------------------------
  // Memory port strobes
  // ---------------------------------------------------------------------------
  property noReadWithWrite;
    @(posedge iClock) disable iff (!rstN) !(mcuReadRequest && mcuWe);
  endproperty

  property writeIsSingle;
    @(posedge iClock) disable iff (!rstN) mcuWe |=> !mcuWe;
  endproperty

  // Opcode read may be followed by one operand read but never a third
  property readPairEnds;
    @(posedge iClock) disable iff (!rstN)
      mcuReadRequest ##1 mcuReadRequest |=> !mcuReadRequest;
  endproperty

  property operandFollowsOpcode;
    @(posedge iClock) disable iff (!rstN)
      mcuReadRequest ##1 mcuReadRequest |-> mcuAddr == $past(mcuAddr) + 16'd1;
  endproperty

  property quietAfterReset;
    @(posedge iClock) $rose(rstN) |-> !mcuReadRequest && !mcuWe;
  endproperty

  aNoReadWithWrite: assert property (noReadWithWrite)
  else
  begin
    failCount++;
    $error("read and write strobe together");
  end

  aWriteIsSingle: assert property (writeIsSingle)
  else
  begin
    failCount++;
    $error("write strobe held two cycles");
  end

  aReadPairEnds: assert property (readPairEnds)
  else
  begin
    failCount++;
    $error("read strobe held three cycles");
  end

  aOperandAddr: assert property (operandFollowsOpcode)
  else
  begin
    failCount++;
    $error("operand read address off");
  end

  aQuietAfterReset: assert property (quietAfterReset)
  else
  begin
    failCount++;
    $error("strobe right after reset");
  end

endmodule

bind gbCore gbCoreProps uProps (
  .iClock(iClock),
  .rstN(rstN),
  .mcuAddr(mcuAddr),
  .mcuReadRequest(mcuReadRequest),
  .mcuWe(mcuWe)
);

// File: bench/gbCoreTb.sv
`timescale 1ns/1ns

module gbCoreTb;
  import gbSysPkg::*;
  import gbIsaPkg::*;

  localparam int clockPeriod = 40;

  logic iClock = 1'b0;
  logic rstN;
  dataT mcuDataIn;
  irqT  interruptRequests;
  addrT mcuAddr;
  dataT mcuDataOut;
  logic mcuReadRequest;
  logic mcuWe;

  dataT        mem [0:65535];
  dataT        shadow [0:7];   // Index 6 unused
  addrT        readQ[$];
  string       readNames[$];
  logic [23:0] writeQ[$];      // Address, data
  string       writeNames[$];
  addrT        trigAddr[$];
  irqT         trigBits[$];
  logic [31:0] lfsrState;
  addrT        cursor;
  string       phase;
  int          totalBytes;
  int          limitCycles;
  int          readErrors;
  int          writeErrors;
  int          otherErrors;
  logic        allDone;
  logic        timedOut;

  gbCore u_dut (
    .iClock(iClock), .rstN(rstN),
    .mcuDataIn(mcuDataIn), .interruptRequests(interruptRequests),
    .mcuAddr(mcuAddr), .mcuDataOut(mcuDataOut),
    .mcuReadRequest(mcuReadRequest), .mcuWe(mcuWe)
  );

  always #(clockPeriod / 2) iClock = ~iClock;

  // Byte shows up the cycle after the strobe
  always @(posedge iClock)
    if (mcuReadRequest)
      mcuDataIn <= mem[mcuAddr];

  // ---------------------------------------------------------------------------
  // Program generator and shadow model
  // ---------------------------------------------------------------------------
  function automatic logic [7:0] takeBits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v[i]      = lfsrState[0];
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
    end
    return v;
  endfunction

  function automatic regCodeT pickReg();
    regCodeT c;
    c = regCodeT'(takeBits(3));
    return (c == regMem) ? regA : c;
  endfunction

  task automatic emitByte(input dataT b);
    mem[cursor] = b;
    readQ.push_back(cursor);
    readNames.push_back(phase);
    cursor = cursor + 16'd1;
    totalBytes++;
  endtask

  task automatic emitLdImm(input regCodeT r, input dataT n);
    emitByte({2'b00, r, 3'd6});
    emitByte(n);
    shadow[r] = n;
  endtask

  task automatic emitStore(input regCodeT r);
    emitByte({2'b01, 3'd6, r});
    writeQ.push_back({shadow[regH], shadow[regL], shadow[r]});
    writeNames.push_back(phase);
  endtask

  task automatic emitRandomOps(input int n);
    logic [2:0] opSel;
    regCodeT    dst;
    regCodeT    src;
    for (int i = 0; i < n; i++)
    begin
      opSel = 3'(takeBits(3));
      dst   = pickReg();
      src   = pickReg();
      case (opSel)
        3'd1:
        begin
          emitByte({5'b10100, src});
          shadow[regA] &= shadow[src];
          dst = regA;
        end
        3'd2:
        begin
          emitByte({5'b10101, src});
          shadow[regA] ^= shadow[src];
          dst = regA;
        end
        3'd3:
        begin
          emitByte({5'b10110, src});
          shadow[regA] |= shadow[src];
          dst = regA;
        end
        3'd4:
        begin
          emitByte({2'b00, dst, 3'd4});
          shadow[dst] = shadow[dst] + 8'd1;
        end
        3'd5:
        begin
          emitByte({2'b00, dst, 3'd5});
          shadow[dst] = shadow[dst] - 8'd1;
        end
        3'd6: emitLdImm(dst, takeBits(8));
        default:
        begin
          emitByte({2'b01, dst, src});
          shadow[dst] = shadow[src];
        end
      endcase
      emitStore(dst);   // Makes the result visible on the bus
    end
  endtask

  task automatic addTrigger(input irqT bits);
    trigAddr.push_back(cursor);
    trigBits.push_back(bits);
  endtask

  task automatic buildProgram();
    lfsrState = 32'h74b608a0;
    for (int i = 0; i < 8; i++)
      shadow[i] = '0;
    for (int i = 0; i < 65536; i++)
      mem[i] = i[15:8] ^ i[7:0];
    cursor = resetPc;
    phase  = "load store";
    emitLdImm(regH, takeBits(8));
    emitLdImm(regL, takeBits(8));
    emitLdImm(regCodeT'(takeBits(2)), takeBits(8));
    emitStore(regCodeT'(mem[16'd4][5:3]));
    phase = "random ops";
    emitRandomOps(3);
    emitByte(opEi);
    emitByte(opNop);
    emitByte(opDi);
    phase = "irq disabled";
    addTrigger(4'b0010);
    emitRandomOps(3);
    addTrigger(4'b1000);
    emitRandomOps(2);
    emitByte(opEi);
    // Latch holds bits 1 and 3 so joypad wins
    cursor = vecJoypad;
    phase  = "irq entry";
    addTrigger(4'b0101);
    emitRandomOps(8);
    emitByte(opEi);
    cursor = vecVblank;
    phase  = "second entry";
    emitRandomOps(3);
    emitByte(opNop);
  endtask

  // ---------------------------------------------------------------------------
  // Bus checks sampled mid-cycle
  // ---------------------------------------------------------------------------
  always @(negedge iClock)
  begin
    addrT        expAddr;
    logic [23:0] expWrite;
    string       name;
    if (rstN && !allDone)
    begin
      if (mcuReadRequest && readQ.size() > 0)
      begin
        expAddr = readQ.pop_front();
        name    = readNames.pop_front();
        assert (mcuAddr == expAddr)
        else
        begin
          readErrors++;
          $display("ERR %s fetch expected %h actual %h", name, expAddr, mcuAddr);
        end
      end
      if (mcuWe && writeQ.size() == 0)
      begin
        otherErrors++;
        $display("Write strobe at %h that the program does not contain", mcuAddr);
      end
      else if (mcuWe)
      begin
        expWrite = writeQ.pop_front();
        name     = writeNames.pop_front();
        assert ({mcuAddr, mcuDataOut} == expWrite)
        else
        begin
          writeErrors++;
          $display("ERR %s store expected %h actual %h", name, expWrite, {mcuAddr, mcuDataOut});
        end
      end
      if (readQ.size() == 0 && writeQ.size() == 0)
        allDone = 1'b1;
    end
  end

  // Request pulses tied to fetch addresses
  initial
  begin
    addrT a;
    irqT  b;
    wait (rstN === 1'b1);
    while (trigAddr.size() > 0)
    begin
      a = trigAddr.pop_front();
      b = trigBits.pop_front();
      do
        @(negedge iClock);
      while (!(mcuReadRequest && mcuAddr == a));
      @(posedge iClock);
      interruptRequests <= b;
      @(posedge iClock);
      interruptRequests <= '0;
    end
  end

  initial
  begin
    rstN              = 1'b0;
    mcuDataIn         = '0;
    interruptRequests = '0;
    readErrors        = 0;
    writeErrors       = 0;
    otherErrors       = 0;
    totalBytes        = 0;
    allDone           = 1'b0;
    timedOut          = 1'b0;
    buildProgram();
    limitCycles = totalBytes * 3 + 60;
    repeat (5) @(posedge iClock);
    rstN <= 1'b1;
    fork
      wait (allDone);
      begin
        repeat (limitCycles) @(posedge iClock);
        timedOut = 1'b1;   // Watchdog
      end
    join_any
    disable fork;
    if (timedOut)
      $display("Timeout: program not finished after %0d cycles", limitCycles);
    $display("Errors: fetch %0d, store %0d, other %0d, protocol %0d",
             readErrors, writeErrors, otherErrors, u_dut.uProps.failCount);
    if (!timedOut && readErrors == 0 && writeErrors == 0 && otherErrors == 0
        && u_dut.uProps.failCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: compile.f
hdl/gbSysPkg.sv
hdl/gbIsaPkg.sv
hdl/regPortIf.sv
hdl/interruptController.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/cpuSequencer.sv
hdl/gbCore.sv
bench/gbCore_props.sv
bench/gbCoreTb.sv
